//--- div_pkg.sv
// Shared widths, pipeline depth and types for the 8-bit divider RTL and its testbench
package div_pkg;

    ////////////////////////////////////////////////////////////
    // Operand sizing
    ////////////////////////////////////////////////////////////

    // Dividend, divisor, quotient and remainder all share this width
    localparam int operand_width = 8;

    // One quotient bit is resolved per stage
    localparam int pipe_depth = operand_width;

    // Capture register, division stages, then the result register
    localparam int latency = pipe_depth + 2;

    ////////////////////////////////////////////////////////////
    // Result counters
    ////////////////////////////////////////////////////////////

    localparam int count_width = 16;  // Wraps silently at full scale

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // Operands, quotients and remainders
    typedef logic [operand_width-1:0] operand_t;

    // Delivered-result and zero-divisor counters
    typedef logic [count_width-1:0] count_t;

endpackage

//--- div_operand_capture.sv
// Input side of the divider that registers each operand pair and flags a zero divisor
`timescale 1ns/1ps

module div_operand_capture (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  div_pkg::operand_t dividend,
    input  div_pkg::operand_t divisor,
    output logic              cap_valid,
    output div_pkg::operand_t cap_dividend,
    output div_pkg::operand_t cap_divisor,
    output logic              cap_zero
);

    ////////////////////////////////////////////////////////////
    // Zero-divisor detect
    ////////////////////////////////////////////////////////////

    // Decided once here and carried down the pipe with the operation,
    // so the later stages never compare the divisor again
    logic divisor_is_zero;

    assign divisor_is_zero = (divisor == '0);

    ////////////////////////////////////////////////////////////
    // Strobe register
    ////////////////////////////////////////////////////////////

    // Follows in_valid every cycle, so back-to-back strobes pass through
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= in_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand registers
    ////////////////////////////////////////////////////////////

    // Load only on a strobe; idle cycles keep the last pair
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cap_dividend <= '0;
            cap_divisor  <= '0;
            cap_zero     <= 1'b0;
        end else if (in_valid) begin
            cap_dividend <= dividend;
            cap_divisor  <= divisor;
            cap_zero     <= divisor_is_zero;  // Travels alongside the pair
        end
    end

endmodule

//--- div_restoring_pipe.sv
// Eight-stage restoring-division pipeline that resolves one quotient bit per stage
`timescale 1ns/1ps

module div_restoring_pipe (
    input  logic              clk,
    input  logic              reset,
    input  logic              cap_valid,
    input  div_pkg::operand_t cap_dividend,
    input  div_pkg::operand_t cap_divisor,
    input  logic              cap_zero,
    output logic              pipe_valid,
    output div_pkg::operand_t pipe_quotient,
    output div_pkg::operand_t pipe_remainder,
    output logic              pipe_zero
);

    ////////////////////////////////////////////////////////////
    // Stage array
    ////////////////////////////////////////////////////////////

    // The quotient register of a stage doubles as the dividend shifter.
    // It enters holding the dividend; each stage shifts the top dividend
    // bit out into the partial remainder and shifts the new quotient bit
    // in at the bottom. After the last stage it holds only quotient bits.
    //
    // A zero divisor needs no special path. Every trial subtraction
    // succeeds, so the quotient fills with ones and the remainder ends
    // up equal to the dividend.

    genvar s;

    generate
        for (s = 0; s < div_pkg::pipe_depth; s++) begin : g_stage

            // Stage registers
            logic              valid_q;
            div_pkg::operand_t rem_q;
            div_pkg::operand_t quo_q;
            div_pkg::operand_t div_q;
            logic              zero_q;

            // Values entering this stage
            logic              src_valid;
            div_pkg::operand_t src_rem;
            div_pkg::operand_t src_quo;
            div_pkg::operand_t src_div;
            logic              src_zero;

            // Trial subtraction, one bit wider than the operands
            logic [div_pkg::operand_width:0] rem_shift;
            logic [div_pkg::operand_width:0] diff;
            logic                            q_bit;
            div_pkg::operand_t               next_rem;

            if (s == 0) begin : g_first
                assign src_valid = cap_valid;
                assign src_rem   = '0;            // Remainder starts empty
                assign src_quo   = cap_dividend;
                assign src_div   = cap_divisor;
                assign src_zero  = cap_zero;
            end else begin : g_next
                assign src_valid = g_stage[s-1].valid_q;
                assign src_rem   = g_stage[s-1].rem_q;
                assign src_quo   = g_stage[s-1].quo_q;
                assign src_div   = g_stage[s-1].div_q;
                assign src_zero  = g_stage[s-1].zero_q;
            end

            // Bring down the next dividend bit
            assign rem_shift = {src_rem, src_quo[div_pkg::operand_width-1]};
            assign diff      = rem_shift - {1'b0, src_div};

            // Top bit set means the subtraction went negative
            assign q_bit = ~diff[div_pkg::operand_width];

            // Keep the difference, or restore the shifted remainder
            assign next_rem = q_bit ? diff[div_pkg::operand_width-1:0]
                                    : rem_shift[div_pkg::operand_width-1:0];

            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    valid_q <= 1'b0;
                    rem_q   <= '0;
                    quo_q   <= '0;
                    div_q   <= '0;
                    zero_q  <= 1'b0;
                end else begin
                    valid_q <= src_valid;
                    if (src_valid) begin
                        rem_q  <= next_rem;
                        quo_q  <= {src_quo[div_pkg::operand_width-2:0], q_bit};
                        div_q  <= src_div;
                        zero_q <= src_zero;
                    end
                end
            end

        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Last stage out
    ////////////////////////////////////////////////////////////

    assign pipe_valid     = g_stage[div_pkg::pipe_depth-1].valid_q;
    assign pipe_quotient  = g_stage[div_pkg::pipe_depth-1].quo_q;   // All dividend bits gone
    assign pipe_remainder = g_stage[div_pkg::pipe_depth-1].rem_q;
    assign pipe_zero      = g_stage[div_pkg::pipe_depth-1].zero_q;

endmodule

//--- div_result_stage.sv
// Output side of the divider that registers each result and counts delivered results
`timescale 1ns/1ps

module div_result_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              pipe_valid,
    input  div_pkg::operand_t pipe_quotient,
    input  div_pkg::operand_t pipe_remainder,
    input  logic              pipe_zero,
    output logic              out_valid,
    output div_pkg::operand_t quotient,
    output div_pkg::operand_t remainder,
    output logic              div_by_zero,
    output div_pkg::count_t   result_count,
    output div_pkg::count_t   zero_count
);

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    // One-cycle strobe per result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pipe_valid;
        end
    end

    // Held between strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            quotient    <= '0;
            remainder   <= '0;
            div_by_zero <= 1'b0;
        end else if (pipe_valid) begin
            quotient    <= pipe_quotient;
            remainder   <= pipe_remainder;
            div_by_zero <= pipe_zero;
        end
    end

    ////////////////////////////////////////////////////////////
    // Result counters
    ////////////////////////////////////////////////////////////

    // Update on the same edge that raises out_valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_count <= '0;
            zero_count   <= '0;
        end else if (pipe_valid) begin
            result_count <= result_count + 1'b1;  // Wraps at full scale
            if (pipe_zero) begin
                zero_count <= zero_count + 1'b1;
            end
        end
    end

endmodule

//--- div_top.sv
// Top level of the pipelined 8-bit divider joining capture, division pipe and result stage
`timescale 1ns/1ps

module div_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  div_pkg::operand_t dividend,
    input  div_pkg::operand_t divisor,
    output logic              out_valid,
    output div_pkg::operand_t quotient,
    output div_pkg::operand_t remainder,
    output logic              div_by_zero,
    output div_pkg::count_t   result_count,
    output div_pkg::count_t   zero_count
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    // Capture to pipe
    logic              cap_valid;
    div_pkg::operand_t cap_dividend;
    div_pkg::operand_t cap_divisor;
    logic              cap_zero;

    // Pipe to result stage
    logic              pipe_valid;
    div_pkg::operand_t pipe_quotient;
    div_pkg::operand_t pipe_remainder;
    logic              pipe_zero;

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////

    div_operand_capture div_operand_capture_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .dividend     (dividend),
        .divisor      (divisor),
        .cap_valid    (cap_valid),
        .cap_dividend (cap_dividend),
        .cap_divisor  (cap_divisor),
        .cap_zero     (cap_zero)
    );

    // Fixed pipe_depth cycles, no stalls
    div_restoring_pipe div_restoring_pipe_inst (
        .clk            (clk),
        .reset          (reset),
        .cap_valid      (cap_valid),
        .cap_dividend   (cap_dividend),
        .cap_divisor    (cap_divisor),
        .cap_zero       (cap_zero),
        .pipe_valid     (pipe_valid),
        .pipe_quotient  (pipe_quotient),
        .pipe_remainder (pipe_remainder),
        .pipe_zero      (pipe_zero)
    );

    div_result_stage div_result_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .pipe_valid     (pipe_valid),
        .pipe_quotient  (pipe_quotient),
        .pipe_remainder (pipe_remainder),
        .pipe_zero      (pipe_zero),
        .out_valid      (out_valid),
        .quotient       (quotient),
        .remainder      (remainder),
        .div_by_zero    (div_by_zero),
        .result_count   (result_count),
        .zero_count     (zero_count)
    );

endmodule

//--- div_asserts.sv
// Concurrent checks on the divider top level, attached to every div_top instance with bind
`timescale 1ns/1ps

module div_asserts (
    input logic            clk,
    input logic            reset,
    input logic            in_valid,
    input logic            out_valid,
    input div_pkg::count_t result_count
);

    // Every accepted operation leaves after the fixed latency
    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##(div_pkg::latency) out_valid)
        else $error("out_valid missing %0d cycles after in_valid", div_pkg::latency);

    // No result without a matching input
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, div_pkg::latency))
        else $error("out_valid with no matching in_valid");

    ////////////////////////////////////////////////////////////
    // Result counter tracks out_valid
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> result_count == $past(result_count) + div_pkg::count_t'(1))
        else $error("result_count did not step with out_valid");

    assert property (@(posedge clk) disable iff (reset)
        !out_valid |-> $stable(result_count))
        else $error("result_count changed without out_valid");

endmodule

bind div_top div_asserts div_asserts_inst (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .result_count (result_count)
);

//--- tb_div.sv
// Self-checking testbench for the pipelined divider; LFSR stimulus checked against a model
`timescale 1ns/1ps

module tb_div;

    ////////////////////////////////////////////////////////////
    // DUT signals, clock and instance
    ////////////////////////////////////////////////////////////

    logic              clk;
    logic              reset;
    logic              in_valid;
    div_pkg::operand_t dividend;
    div_pkg::operand_t divisor;
    logic              out_valid;
    div_pkg::operand_t quotient;
    div_pkg::operand_t remainder;
    logic              div_by_zero;
    div_pkg::count_t   result_count;
    div_pkg::count_t   zero_count;

    div_top div_top_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .dividend     (dividend),
        .divisor      (divisor),
        .out_valid    (out_valid),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_by_zero  (div_by_zero),
        .result_count (result_count),
        .zero_count   (zero_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    ////////////////////////////////////////////////////////////
    // Bookkeeping
    ////////////////////////////////////////////////////////////

    int          cycle_count = 0;  // Rising edges seen so far
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    int          sent_total = 0;
    int          zero_total = 0;
    string       test_name;
    logic [15:0] lfsr_state = 16'd43305;

    // Expected results in input order, with the cycle each input was seen
    div_pkg::operand_t exp_quo_q[$];
    div_pkg::operand_t exp_rem_q[$];
    logic              exp_zero_q[$];
    int                exp_cycle_q[$];

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic random_bits(input int n, output div_pkg::operand_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step per bit
            value = {value[div_pkg::operand_width-2:0], lfsr_state[0]};
        end
    endtask

    // All ones for a zero divisor, as restoring division yields
    function automatic div_pkg::operand_t model_quotient(input div_pkg::operand_t a,
                                                         input div_pkg::operand_t b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    function automatic div_pkg::operand_t model_remainder(input div_pkg::operand_t a,
                                                          input div_pkg::operand_t b);
        if (b == '0) begin
            return a;  // Dividend passes through untouched
        end
        return a % b;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_result(input div_pkg::operand_t got_quo, input div_pkg::operand_t exp_quo,
                                input div_pkg::operand_t got_rem, input div_pkg::operand_t exp_rem,
                                input logic got_zero, input logic exp_zero);
        if (got_quo !== exp_quo || got_rem !== exp_rem || got_zero !== exp_zero) begin
            errors++;
            $display("FAILED at %0t: result q=%h r=%h z=%b, expected q=%h r=%h z=%b",
                     $time, got_quo, got_rem, got_zero, exp_quo, exp_rem, exp_zero);
        end
    endtask

    task automatic check_count(input string what, input div_pkg::count_t got,
                               input div_pkg::count_t expected);
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("FAILED at %0t: result came %0d cycles after its input, expected %0d",
                     $time, got, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor sampled mid-cycle where everything is stable
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        int sent_cycle;
        if (!reset) begin
            if (out_valid) begin
                if (exp_quo_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: out_valid rose with no operation outstanding", $time);
                end else begin
                    check_result(quotient, exp_quo_q.pop_front(), remainder,
                                 exp_rem_q.pop_front(), div_by_zero, exp_zero_q.pop_front());
                    sent_cycle = exp_cycle_q.pop_front();
                    check_latency(cycle_count - sent_cycle, div_pkg::latency);
                end
            end
            if (in_valid) begin  // Sampled by the DUT on the next edge
                exp_quo_q.push_back(model_quotient(dividend, divisor));
                exp_rem_q.push_back(model_remainder(dividend, divisor));
                exp_zero_q.push_back(divisor == '0);
                exp_cycle_q.push_back(cycle_count);
                sent_total++;
                if (divisor == '0) begin
                    zero_total++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and test sequencing
    ////////////////////////////////////////////////////////////

    task automatic drive_op(input div_pkg::operand_t a, input div_pkg::operand_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        dividend <= a;
        divisor  <= b;
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Drop the strobe, then wait for every outstanding result
    task automatic wait_results(input int limit);
        int waited;
        waited = 0;
        go_idle(1);
        while (exp_quo_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        if (exp_quo_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d results still missing after %0d cycles",
                     exp_quo_q.size(), limit);
            exp_quo_q.delete();
            exp_rem_q.delete();
            exp_zero_q.delete();
            exp_cycle_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        div_pkg::operand_t a;
        div_pkg::operand_t b;
        div_pkg::operand_t pick;
        int                sent;

        reset    = 1'b1;
        in_valid = 1'b0;
        dividend = '0;
        divisor  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start_test("reset state");
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("div_by_zero", div_by_zero, 1'b0);
        check_count("result_count", result_count, '0);
        check_count("zero_count", zero_count, '0);
        finish_test();

        start_test("single operations");
        repeat (8) begin
            random_bits(8, a);
            random_bits(8, b);
            if (b == '0) begin
                b = 8'd1;
            end
            drive_op(a, b);
            wait_results(div_pkg::latency + 8);
        end
        finish_test();

        start_test("back-to-back operations");
        repeat (16) begin
            random_bits(8, a);
            random_bits(8, b);
            if (b == '0) begin
                b = 8'd1;
            end
            drive_op(a, b);  // One per cycle, no gaps
        end
        wait_results(div_pkg::latency + 24);
        finish_test();

        start_test("zero divisor");
        repeat (6) begin
            random_bits(8, a);
            drive_op(a, '0);
        end
        wait_results(div_pkg::latency + 16);
        check_count("zero_count", zero_count, div_pkg::count_t'(zero_total));
        check_count("result_count", result_count, div_pkg::count_t'(sent_total));
        finish_test();

        start_test("gapped random traffic");
        sent = 0;
        while (sent < 300) begin
            random_bits(1, pick);
            if (pick[0]) begin
                random_bits(8, a);
                random_bits(8, b);
                random_bits(3, pick);
                if (pick[2:0] == 3'd0) begin
                    b = '0;  // About one in eight
                end
                drive_op(a, b);
                sent++;
            end else begin
                go_idle(1);
            end
        end
        wait_results(div_pkg::latency + 20);
        check_count("result_count", result_count, div_pkg::count_t'(sent_total));
        check_count("zero_count", zero_count, div_pkg::count_t'(zero_total));
        finish_test();

        start_test("edge operands");
        drive_op(8'd200, 8'd1);
        drive_op(8'd0, 8'd37);
        drive_op(8'd5, 8'd200);   // Dividend below divisor
        drive_op(8'd255, 8'd255);
        drive_op(8'd255, 8'd1);
        wait_results(div_pkg::latency + 16);
        finish_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
div_pkg.sv
div_operand_capture.sv
div_restoring_pipe.sv
div_result_stage.sv
div_top.sv
div_asserts.sv
tb_div.sv

//--- Makefile
# Verilator build and run of the divider testbench

TOP = tb_div

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
